// ==== logic/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

`define DATA_W    32
`define ADDR_W    32
`define SET_W     3
`define WAYS      4
`define WAY_W     2
`define BYTE_OFF  2
`define MEM_AW    8

// Derived sizes
`define TAG_W     (`ADDR_W - `SET_W - `BYTE_OFF)
`define SETS      (1 << `SET_W)
`define MEM_DEPTH (1 << `MEM_AW)

`endif

// ==== logic/cache_types_pkg.sv ====
`include "cache_macros.svh"

package cache_types_pkg;

    // Upper address bits kept per line
    typedef logic [`TAG_W-1:0] tag_t;

    typedef logic [`SET_W-1:0] set_t;

    typedef logic [`WAY_W-1:0] way_t;

    // Bookkeeping stored next to each data word
    typedef struct packed {
        logic valid;
        logic dirty; // Newer than backing memory
        tag_t tag;
    } line_state_t;

endpackage

// ==== logic/bus_types_pkg.sv ====
`include "cache_macros.svh"

package bus_types_pkg;

    // Processor side, byte addressed
    typedef struct packed {
        logic              we;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`DATA_W-1:0] rdata;
        logic               hit; // Served without memory traffic
    } cpu_rsp_t;

    // Memory side, word addressed
    typedef struct packed {
        logic               we;
        logic [`MEM_AW-1:0] addr;
        logic [`DATA_W-1:0] wdata;
    } mem_req_t;

endpackage

// ==== logic/cache_array.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_array import cache_types_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`ADDR_W-1:0] lookup_addr,
    input  logic               wr_en,
    input  way_t               wr_way,
    input  line_state_t        wr_state,
    input  logic [`DATA_W-1:0] wr_data,
    input  logic               advance,
    output logic               hit,
    output way_t               hit_way,
    output logic [`DATA_W-1:0] hit_data,
    output way_t               victim_way,
    output line_state_t        victim_state,
    output logic [`DATA_W-1:0] victim_data
);
    set_t               set_idx;
    tag_t               tag_in;
    logic [`WAYS-1:0]   valid_q [`SETS];
    logic [`WAYS-1:0]   dirty_q [`SETS];
    tag_t               tag_q   [`SETS][`WAYS];
    logic [`DATA_W-1:0] data_q  [`SETS][`WAYS];
    way_t               ptr_q   [`SETS]; // Round-robin victim per set

    assign set_idx = lookup_addr[`BYTE_OFF +: `SET_W];
    assign tag_in  = lookup_addr[`ADDR_W-1 -: `TAG_W];

    // All four ways of the set compared in parallel
    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        hit_data = '0;
        for (int w = 0; w < `WAYS; w++) begin
            if (valid_q[set_idx][w] && (tag_q[set_idx][w] == tag_in)) begin
                hit      = 1'b1;
                hit_way  = way_t'(w);
                hit_data = data_q[set_idx][w];
            end
        end
    end

    assign victim_way   = ptr_q[set_idx];
    assign victim_state = {valid_q[set_idx][victim_way],
                           dirty_q[set_idx][victim_way],
                           tag_q[set_idx][victim_way]};
    assign victim_data  = data_q[set_idx][victim_way];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                ptr_q[s]   <= '0;
            end
        end else begin
            if (wr_en) begin
                valid_q[set_idx][wr_way] <= wr_state.valid;
                dirty_q[set_idx][wr_way] <= wr_state.dirty;
            end
            if (advance) begin
                ptr_q[set_idx] <= way_t'(ptr_q[set_idx] + 1'b1); // Wraps after way 3
            end
        end
    end

    // Tag and word storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[set_idx][wr_way]  <= wr_state.tag;
            data_q[set_idx][wr_way] <= wr_data;
        end
    end

endmodule

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_ctrl import cache_types_pkg::*, bus_types_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_req_t           cpu_req,
    input  logic               req,
    output cpu_rsp_t           cpu_rsp,
    output logic               ack,
    output logic [`ADDR_W-1:0] lookup_addr,
    output logic               wr_en,
    output way_t               wr_way,
    output line_state_t        wr_state,
    output logic [`DATA_W-1:0] wr_data,
    output logic               advance,
    input  logic               hit,
    input  way_t               hit_way,
    input  logic [`DATA_W-1:0] hit_data,
    input  way_t               victim_way,
    input  line_state_t        victim_state,
    input  logic [`DATA_W-1:0] victim_data,
    output mem_req_t           mem_req,
    output logic               mem_req_valid,
    input  logic [`DATA_W-1:0] mem_rdata,
    input  logic               mem_ack
);
    typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, FILL, RESPOND, RELEASE} state_t;

    state_t                    state_q;
    cpu_req_t                  req_q;
    cpu_rsp_t                  rsp_q;
    logic                      ack_q;
    logic                      fill_done_q;
    logic                      victim_dirty;
    logic                      hit_write;
    logic                      install;
    tag_t                      req_tag;
    set_t                      req_set;
    logic [`TAG_W+`SET_W-1:0]  wb_word; // Victim's word address

    assign req_tag      = req_q.addr[`ADDR_W-1 -: `TAG_W];
    assign req_set      = req_q.addr[`BYTE_OFF +: `SET_W];
    assign wb_word      = {victim_state.tag, req_set};
    assign victim_dirty = victim_state.valid && victim_state.dirty;
    assign lookup_addr  = req_q.addr;

    // Install is either a clean write miss or the end of the last memory handshake
    assign hit_write = (state_q == LOOKUP) && hit && req_q.we;
    assign install   = ((state_q == LOOKUP) && !hit && req_q.we && !victim_dirty) ||
                       ((state_q == RELEASE) && !mem_ack && (req_q.we || fill_done_q));

    assign wr_en    = hit_write || install;
    assign wr_way   = hit_write ? hit_way : victim_way;
    assign wr_state = '{valid: 1'b1, dirty: req_q.we, tag: req_tag};
    assign wr_data  = req_q.we ? req_q.wdata : mem_rdata;
    assign advance  = install;

    always_comb begin
        mem_req       = '0;
        mem_req_valid = 1'b0;
        if (state_q == WRITEBACK) begin
            mem_req.we    = 1'b1;
            mem_req.addr  = wb_word[`MEM_AW-1:0];
            mem_req.wdata = victim_data;
            mem_req_valid = 1'b1;
        end else if (state_q == FILL) begin
            mem_req.addr  = req_q.addr[`BYTE_OFF +: `MEM_AW];
            mem_req_valid = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            ack_q       <= 1'b0;
            fill_done_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req) begin
                        state_q     <= LOOKUP;
                        fill_done_q <= 1'b0;
                    end
                end
                LOOKUP: begin
                    if (hit || install) begin
                        ack_q   <= 1'b1;
                        state_q <= RESPOND;
                    end else if (victim_dirty) begin
                        state_q <= WRITEBACK;
                    end else begin
                        state_q <= FILL;
                    end
                end
                WRITEBACK: if (mem_ack) state_q <= RELEASE;
                FILL: begin
                    if (mem_ack) begin
                        fill_done_q <= 1'b1;
                        state_q     <= RELEASE;
                    end
                end
                RELEASE: begin
                    // Wait for memory ack to return low
                    if (!mem_ack) begin
                        if (install) begin
                            ack_q   <= 1'b1;
                            state_q <= RESPOND;
                        end else begin
                            state_q <= FILL; // Read miss after write-back
                        end
                    end
                end
                RESPOND: begin
                    if (!req) begin
                        ack_q   <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && req) begin
            req_q <= cpu_req;
        end
        if ((state_q == LOOKUP) && hit) begin
            rsp_q <= '{rdata: req_q.we ? req_q.wdata : hit_data, hit: 1'b1};
        end else if (install) begin
            rsp_q <= '{rdata: wr_data, hit: 1'b0};
        end
    end

    assign cpu_rsp = rsp_q;
    assign ack     = ack_q;

endmodule

// ==== logic/main_mem.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module main_mem import bus_types_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_req_t           mem_req,
    input  logic               mem_req_valid,
    output logic [`DATA_W-1:0] mem_rdata,
    output logic               mem_ack
);
    logic [`DATA_W-1:0] mem [`MEM_DEPTH];
    logic               start; // First cycle of a new handshake

    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign start = mem_req_valid && !mem_ack;

    // Ack follows valid with one cycle of delay in both directions
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= mem_req_valid;
        end
    end

    // Read data stays put until the next read
    always @(posedge clk) begin
        if (start) begin
            if (mem_req.we) begin
                mem[mem_req.addr] <= mem_req.wdata;
            end else begin
                mem_rdata <= mem[mem_req.addr];
            end
        end
    end

endmodule

// ==== logic/dcache_top.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module dcache_top import bus_types_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req,
    input  cpu_req_t cpu_req,
    output logic     ack,
    output cpu_rsp_t cpu_rsp
);
    logic [`ADDR_W-1:0] lookup_addr;
    logic               wr_en;
    logic [`WAY_W-1:0]  wr_way;
    logic [`TAG_W+1:0]  wr_state;     // valid, dirty, tag
    logic [`DATA_W-1:0] wr_data;
    logic               advance;
    logic               hit;
    logic [`WAY_W-1:0]  hit_way;
    logic [`DATA_W-1:0] hit_data;
    logic [`WAY_W-1:0]  victim_way;
    logic [`TAG_W+1:0]  victim_state;
    logic [`DATA_W-1:0] victim_data;
    mem_req_t           mem_req;
    logic               mem_req_valid;
    logic [`DATA_W-1:0] mem_rdata;
    logic               mem_ack;

    cache_ctrl u_ctrl (.*);

    cache_array u_array (.*);

    main_mem u_mem (.*);

endmodule

// ==== tests/dcache_props.sv ====
`timescale 1ns/1ps

module dcache_props (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic ack
);

    // Ack only ever answers a request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    ack_held_until_release: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && req) |=> ack)
        else $error("ack dropped while req was still high");

    // Req may only fall once ack is up
    req_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (req && !ack) |=> (req || ack))
        else $error("req dropped before ack");

    ack_low_in_reset: assert property (@(posedge clk) !rst_n |-> !ack)
        else $error("ack high during reset");

endmodule

bind cache_ctrl dcache_props u_props (.clk(clk), .rst_n(rst_n), .req(req), .ack(ack));

// ==== tests/dcache_tb.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module dcache_tb import bus_types_pkg::*; ();

    logic     clk;
    logic     rst_n;
    logic     req;
    logic     ack;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;

    int          seed;
    int          total_ops;
    bit          loaded;
    logic        op_q   [$]; // 1 means write
    logic [31:0] addr_q [$];
    logic [31:0] data_q [$];

    // Reference model state
    logic               valid_m [`SETS][`WAYS];
    logic [`TAG_W-1:0]  tag_m   [`SETS][`WAYS];
    logic [1:0]         ptr_m   [`SETS];
    logic [31:0]        mem_m   [`MEM_DEPTH];

    dcache_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .cpu_req (cpu_req),
        .ack     (ack),
        .cpu_rsp (cpu_rsp)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic load_ops();
        int          fd;
        int          op;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("tests/dcache_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/dcache_input.txt");
            $display("Test failed");
            $fatal(1, "no stimulus file");
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%d %h %h", op, a, d) == 3) begin // Comment lines fall through
                op_q.push_back(op != 0);
                addr_q.push_back(a);
                data_q.push_back(d);
            end
        end
        $fclose(fd);
    endtask

    task automatic add_random_ops(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            op_q.push_back(r[31]);
            addr_q.push_back({22'd0, r[9:2], 2'b00}); // First 1 KB only
            data_q.push_back($random(seed));
        end
    endtask

    // Expected read data and hit flag, model updated as a side effect
    task automatic predict(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                           output logic [31:0] exp_data, output logic exp_hit);
        logic [`SET_W-1:0]  s;
        logic [`TAG_W-1:0]  t;
        logic [`MEM_AW-1:0] w;
        s = addr[`BYTE_OFF +: `SET_W];
        t = addr[`ADDR_W-1 -: `TAG_W];
        w = addr[`BYTE_OFF +: `MEM_AW];
        exp_hit = 1'b0;
        for (int k = 0; k < `WAYS; k++) begin
            if (valid_m[s][k] && (tag_m[s][k] == t)) begin
                exp_hit = 1'b1;
            end
        end
        if (!exp_hit) begin
            valid_m[s][ptr_m[s]] = 1'b1;
            tag_m[s][ptr_m[s]]   = t;
            ptr_m[s]             = ptr_m[s] + 2'd1;
        end
        if (we) begin
            mem_m[w] = wdata;
        end
        exp_data = mem_m[w];
    endtask

    // One full four-phase transaction, entered on a falling edge
    task automatic run_op(input logic we, input logic [31:0] addr, input logic [31:0] wdata);
        cpu_rsp_t    rsp;
        logic [31:0] exp_data;
        logic        exp_hit;
        int          waits;
        int          hold;
        predict(we, addr, wdata, exp_data, exp_hit);
        hold    = {$random(seed)} % 3; // Extra cycles with req high after ack
        cpu_req = '{we: we, addr: addr, wdata: wdata};
        req     = 1'b1;
        waits   = 0;
        while (!ack) begin
            @(negedge clk);
            waits++;
        end
        rsp = cpu_rsp;
        check_value("cpu_rsp.rdata", rsp.rdata, exp_data);
        check_value("cpu_rsp.hit", 32'(rsp.hit), 32'(exp_hit));
        if (exp_hit) begin
            check_value("hit latency", waits, 32'd2); // Latch edge, then result edge
        end
        repeat (hold) @(negedge clk);
        check_value("ack while req held", 32'(ack), 32'd1);
        req   = 1'b0;
        waits = 0;
        while (ack) begin
            @(negedge clk);
            waits++;
        end
        check_value("ack release latency", waits, 32'd1);
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        req     = 1'b0;
        cpu_req = '0;
        seed    = 40;
        for (int s = 0; s < `SETS; s++) begin
            ptr_m[s] = 2'd0;
            for (int k = 0; k < `WAYS; k++) begin
                valid_m[s][k] = 1'b0;
            end
        end
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem_m[i] = '0;
        end
        load_ops();
        add_random_ops(200);
        total_ops = op_q.size();
        loaded    = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < total_ops; i++) begin
            run_op(op_q[i], addr_q[i], data_q[i]);
        end
        $display("Test passed");
        $finish;
    end

    // Worst-case miss is far below 40 cycles
    initial begin
        wait (loaded);
        #(total_ops * 40 * 8);
        $display("Timed out waiting for ack from the cache");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== tests/dcache_input.txt ====
// op: 0 read, 1 write | addr: byte address in hex | wdata: write data in hex, unused on reads
// Runs in order ahead of the random phase
0 00000100 00000000
1 00000104 11112222
0 00000104 00000000
1 00000104 33334444
0 00000104 00000000
1 00000000 aabb0000
1 00000020 aabb0020
1 00000040 aabb0040
1 00000060 aabb0060
0 00000000 00000000
0 00000040 00000000
1 00000080 aabb0080
0 00000000 00000000
0 00000020 00000000
0 00000080 00000000
0 00000040 00000000
0 00000060 00000000
0 00000080 00000000
1 00000300 0badf00d
0 00000300 00000000
0 00000308 00000000
1 000003e0 5a5a5a5a
0 000003e0 00000000
0 00000100 00000000
1 00000000 c0ffee01
0 00000000 00000000

// ==== verilog.f ====
+incdir+logic
logic/cache_types_pkg.sv
logic/bus_types_pkg.sv
logic/cache_array.sv
logic/cache_ctrl.sv
logic/main_mem.sv
logic/dcache_top.sv
tests/dcache_props.sv
tests/dcache_tb.sv

// ==== Makefile ====
TOP = dcache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
